// ==== dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Instructions per dispatch group.
`define DISPATCH_WIDTH 4

// Branch checkpoints, one mask bit each.
`define CHECKPOINTS 8
`define CHECKPOINTS_LOG 3

// Register and PC widths.
`define SIZE_PHYSICAL_LOG 7
`define SIZE_RMT_LOG 5
`define SIZE_PC 32

// Back-end structure sizes.
`define SIZE_LSQ 16
`define SIZE_LSQ_LOG 4
`define SIZE_ISSUEQ 32
`define SIZE_ISSUEQ_LOG 5
`define SIZE_ACTIVELIST 64
`define SIZE_ACTIVELIST_LOG 6

`endif

// ==== dispatchPkg.sv ====
`include "dispatch_settings.svh"

package dispatchPkg;

  // Physical register tag.
  typedef logic [`SIZE_PHYSICAL_LOG-1:0] physReg_t;

  // Architectural register index.
  typedef logic [`SIZE_RMT_LOG-1:0] archReg_t;

  // Program counter.
  typedef logic [`SIZE_PC-1:0] pc_t;

  // One bit per outstanding branch checkpoint.
  typedef logic [`CHECKPOINTS-1:0] checkpointMask_t;

  // Checkpoint index.
  typedef logic [`CHECKPOINTS_LOG-1:0] checkpointId_t;

  // Occupancy counts carry one bit above the log size,
  // so a completely full structure is representable.
  typedef logic [`SIZE_LSQ_LOG:0] lsqCnt_t;
  typedef logic [`SIZE_ISSUEQ_LOG:0] iqCnt_t;
  typedef logic [`SIZE_ACTIVELIST_LOG:0] alCnt_t;

  // Functional unit class of an instruction.
  typedef enum logic [1:0] {
    INST_SIMPLE  = 2'd0,
    INST_COMPLEX = 2'd1,
    INST_CONTROL = 2'd2,
    INST_MEMORY  = 2'd3
  } instType_e;

endpackage

// ==== branchMaskUpdate.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module branchMaskUpdate (
  input  logic                         clk,
  input  logic                         rst_i,
  input  dispatchPkg::checkpointMask_t branchMaskIn_i [`DISPATCH_WIDTH],
  input  logic                         ctrlVerified_i,
  input  dispatchPkg::checkpointId_t   ctrlVerifiedId_i,
  output dispatchPkg::checkpointMask_t branchMask_o [`DISPATCH_WIDTH]
);

  // One-hot of the released checkpoint, zero when nothing resolved.
  dispatchPkg::checkpointMask_t clearMask;

  always_comb begin
    clearMask = '0;
    if (ctrlVerified_i) begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  // A correctly resolved branch no longer shadows younger instructions.
  always_comb begin
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      branchMask_o[s] = branchMaskIn_i[s] & ~clearMask;
    end
  end

  // Verified checkpoint must be gone from every slot.
  for (genvar s = 0; s < `DISPATCH_WIDTH; s++) begin : gMaskCheck
    assert property (
      @(posedge clk) disable iff (rst_i)
      ctrlVerified_i |-> !branchMask_o[s][ctrlVerifiedId_i]
    ) else $error("slot %0d keeps verified checkpoint %0d", s, ctrlVerifiedId_i);
  end

endmodule

// ==== capacityCheck.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module capacityCheck (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 isLoad_i [`DISPATCH_WIDTH],
  input  logic                 isStore_i [`DISPATCH_WIDTH],
  input  logic                 renameReady_i,
  input  logic                 flagRecoverEX_i,
  input  dispatchPkg::lsqCnt_t loadQueueCnt_i,
  input  dispatchPkg::lsqCnt_t storeQueueCnt_i,
  input  dispatchPkg::iqCnt_t  issueQueueCnt_i,
  input  dispatchPkg::alCnt_t  activeListCnt_i,
  output logic                 backEndReady_o,
  output logic                 stallFrontEnd_o
);

  // Wide enough to count every slot of the group.
  localparam int CntW = $clog2(`DISPATCH_WIDTH + 1);

  // Sums get one bit of headroom above the occupancy width.
  localparam int LsqSumW = `SIZE_LSQ_LOG + 2;
  localparam int IqSumW  = `SIZE_ISSUEQ_LOG + 2;
  localparam int AlSumW  = `SIZE_ACTIVELIST_LOG + 2;

  logic [CntW-1:0]    loadCnt;
  logic [CntW-1:0]    storeCnt;
  logic [LsqSumW-1:0] loadTotal;
  logic [LsqSumW-1:0] storeTotal;
  logic [IqSumW-1:0]  iqTotal;
  logic [AlSumW-1:0]  alTotal;
  logic               loadStall;
  logic               storeStall;
  logic               iqStall;
  logic               alStall;
  logic               stall;

  // Loads and stores in the incoming group.
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      loadCnt  = loadCnt + CntW'(isLoad_i[s]);
      storeCnt = storeCnt + CntW'(isStore_i[s]);
    end
  end

  // Only memory ops need LSQ entries.
  assign loadTotal  = LsqSumW'(loadQueueCnt_i) + LsqSumW'(loadCnt);
  assign storeTotal = LsqSumW'(storeQueueCnt_i) + LsqSumW'(storeCnt);

  // Every slot takes an issue queue and active list entry.
  assign iqTotal = IqSumW'(issueQueueCnt_i) + IqSumW'(`DISPATCH_WIDTH);
  assign alTotal = AlSumW'(activeListCnt_i) + AlSumW'(`DISPATCH_WIDTH);

  assign loadStall  = (loadTotal > LsqSumW'(`SIZE_LSQ));
  assign storeStall = (storeTotal > LsqSumW'(`SIZE_LSQ));
  assign iqStall    = (iqTotal > IqSumW'(`SIZE_ISSUEQ));
  assign alStall    = (alTotal > AlSumW'(`SIZE_ACTIVELIST));

  assign stall = loadStall | storeStall | iqStall | alStall;

  // Rename and decode hold while any structure lacks room.
  assign stallFrontEnd_o = stall;

  // Group moves only with room, a valid group and no recovery in flight.
  assign backEndReady_o = ~stall & renameReady_i & ~flagRecoverEX_i;

  // Accepting a group while stalling would lose or duplicate it.
  assert property (
    @(posedge clk) disable iff (rst_i)
    !(backEndReady_o && stallFrontEnd_o)
  ) else $error("back end ready while front end stalled");

endmodule

// ==== dispatch.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         renameReady_i,
  input  logic                         flagRecoverEX_i,
  input  logic                         ctrlVerified_i,
  input  dispatchPkg::checkpointId_t   ctrlVerifiedId_i,

  // Renamed group, one entry per slot.
  input  dispatchPkg::archReg_t        archDest_i [`DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t        physDest_i [`DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t        oldPhysDest_i [`DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t        physSrc1_i [`DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t        physSrc2_i [`DISPATCH_WIDTH],
  input  logic                         isLoad_i [`DISPATCH_WIDTH],
  input  logic                         isStore_i [`DISPATCH_WIDTH],
  input  dispatchPkg::checkpointMask_t branchMask_i [`DISPATCH_WIDTH],
  input  dispatchPkg::checkpointId_t   checkpointId_i [`DISPATCH_WIDTH],
  input  dispatchPkg::instType_e       instType_i [`DISPATCH_WIDTH],
  input  dispatchPkg::pc_t             pc_i [`DISPATCH_WIDTH],

  // Current back-end occupancy.
  input  dispatchPkg::lsqCnt_t         loadQueueCnt_i,
  input  dispatchPkg::lsqCnt_t         storeQueueCnt_i,
  input  dispatchPkg::iqCnt_t          issueQueueCnt_i,
  input  dispatchPkg::alCnt_t          activeListCnt_i,

  // Issue queue fields.
  output dispatchPkg::physReg_t        iqPhysDest_o [`DISPATCH_WIDTH],
  output dispatchPkg::physReg_t        iqPhysSrc1_o [`DISPATCH_WIDTH],
  output dispatchPkg::physReg_t        iqPhysSrc2_o [`DISPATCH_WIDTH],
  output dispatchPkg::checkpointId_t   iqCheckpointId_o [`DISPATCH_WIDTH],
  output dispatchPkg::instType_e       iqInstType_o [`DISPATCH_WIDTH],

  // Active list fields.
  output dispatchPkg::archReg_t        alArchDest_o [`DISPATCH_WIDTH],
  output dispatchPkg::physReg_t        alPhysDest_o [`DISPATCH_WIDTH],
  output dispatchPkg::physReg_t        alOldPhysDest_o [`DISPATCH_WIDTH],
  output dispatchPkg::pc_t             alPc_o [`DISPATCH_WIDTH],

  // Shared by issue queue, active list, LSQ and the rename pipeline register.
  output logic                         isLoad_o [`DISPATCH_WIDTH],
  output logic                         isStore_o [`DISPATCH_WIDTH],
  output dispatchPkg::checkpointMask_t updatedBranchMask_o [`DISPATCH_WIDTH],

  output logic                         backEndReady_o,
  output logic                         stallFrontEnd_o
);

  // Masks also feed back to rename so a held group sees the release.
  branchMaskUpdate uMaskUpdate (
    .clk              (clk),
    .rst_i            (rst_i),
    .branchMaskIn_i   (branchMask_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .branchMask_o     (updatedBranchMask_o)
  );

  // Room check over all four back-end structures.
  capacityCheck uCapacity (
    .clk             (clk),
    .rst_i           (rst_i),
    .isLoad_i        (isLoad_i),
    .isStore_i       (isStore_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

  // Same field mapping in every slot.
  for (genvar s = 0; s < `DISPATCH_WIDTH; s++) begin : gSlot

    // Operands and wakeup tag for the scheduler.
    assign iqPhysDest_o[s]     = physDest_i[s];
    assign iqPhysSrc1_o[s]     = physSrc1_i[s];
    assign iqPhysSrc2_o[s]     = physSrc2_i[s];
    assign iqCheckpointId_o[s] = checkpointId_i[s];
    assign iqInstType_o[s]     = instType_i[s];

    // Old mapping is freed at retire, PC kept for recovery.
    assign alArchDest_o[s]    = archDest_i[s];
    assign alPhysDest_o[s]    = physDest_i[s];
    assign alOldPhysDest_o[s] = oldPhysDest_i[s];
    assign alPc_o[s]          = pc_i[s];

    // Memory flags.
    assign isLoad_o[s]  = isLoad_i[s];
    assign isStore_o[s] = isStore_i[s];

  end

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset drops on a falling edge, like every other input.
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== tbDispatch.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module tbDispatch;

  localparam int ClkHalf     = 20;
  localparam int ResetCycles = 3;
  localparam int NumDirected = 43;
  localparam int NumRandom   = 2000;
  // Every group takes one cycle, plus some slack.
  localparam int CycleLimit  = ResetCycles + NumDirected + NumRandom + 150;

  logic clk;
  logic rst;
  logic renameReady;
  logic flagRecoverEX;
  logic ctrlVerified;
  dispatchPkg::checkpointId_t   ctrlVerifiedId;
  dispatchPkg::archReg_t        archDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        physDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        oldPhysDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        physSrc1 [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        physSrc2 [`DISPATCH_WIDTH];
  logic                         isLoad [`DISPATCH_WIDTH];
  logic                         isStore [`DISPATCH_WIDTH];
  dispatchPkg::checkpointMask_t branchMask [`DISPATCH_WIDTH];
  dispatchPkg::checkpointId_t   checkpointId [`DISPATCH_WIDTH];
  dispatchPkg::instType_e       instType [`DISPATCH_WIDTH];
  dispatchPkg::pc_t             pc [`DISPATCH_WIDTH];
  dispatchPkg::lsqCnt_t         loadQueueCnt;
  dispatchPkg::lsqCnt_t         storeQueueCnt;
  dispatchPkg::iqCnt_t          issueQueueCnt;
  dispatchPkg::alCnt_t          activeListCnt;

  dispatchPkg::physReg_t        iqPhysDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        iqPhysSrc1 [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        iqPhysSrc2 [`DISPATCH_WIDTH];
  dispatchPkg::checkpointId_t   iqCheckpointId [`DISPATCH_WIDTH];
  dispatchPkg::instType_e       iqInstType [`DISPATCH_WIDTH];
  dispatchPkg::archReg_t        alArchDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        alPhysDest [`DISPATCH_WIDTH];
  dispatchPkg::physReg_t        alOldPhysDest [`DISPATCH_WIDTH];
  dispatchPkg::pc_t             alPc [`DISPATCH_WIDTH];
  logic                         isLoadOut [`DISPATCH_WIDTH];
  logic                         isStoreOut [`DISPATCH_WIDTH];
  dispatchPkg::checkpointMask_t updatedBranchMask [`DISPATCH_WIDTH];
  logic                         backEndReady;
  logic                         stallFrontEnd;

  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;

  tbClock #(.PeriodNs(2 * ClkHalf), .ResetCycles(ResetCycles)) uClock (
    .clk_o (clk),
    .rst_o (rst)
  );

  dispatch DUT (
    .clk(clk), .rst_i(rst), .renameReady_i(renameReady), .flagRecoverEX_i(flagRecoverEX),
    .ctrlVerified_i(ctrlVerified), .ctrlVerifiedId_i(ctrlVerifiedId),
    .archDest_i(archDest), .physDest_i(physDest), .oldPhysDest_i(oldPhysDest),
    .physSrc1_i(physSrc1), .physSrc2_i(physSrc2), .isLoad_i(isLoad), .isStore_i(isStore),
    .branchMask_i(branchMask), .checkpointId_i(checkpointId), .instType_i(instType),
    .pc_i(pc), .loadQueueCnt_i(loadQueueCnt), .storeQueueCnt_i(storeQueueCnt),
    .issueQueueCnt_i(issueQueueCnt), .activeListCnt_i(activeListCnt),
    .iqPhysDest_o(iqPhysDest), .iqPhysSrc1_o(iqPhysSrc1), .iqPhysSrc2_o(iqPhysSrc2),
    .iqCheckpointId_o(iqCheckpointId), .iqInstType_o(iqInstType),
    .alArchDest_o(alArchDest), .alPhysDest_o(alPhysDest), .alOldPhysDest_o(alOldPhysDest),
    .alPc_o(alPc), .isLoad_o(isLoadOut), .isStore_o(isStoreOut),
    .updatedBranchMask_o(updatedBranchMask),
    .backEndReady_o(backEndReady), .stallFrontEnd_o(stallFrontEnd)
  );

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
    end
  endtask

  // Mostly lands within a few entries of the limit.
  function automatic int biasedCount(input int limit);
    if ($urandom_range(0, 3) != 0) begin
      return limit - int'($urandom_range(0, `DISPATCH_WIDTH + 2));
    end
    return int'($urandom_range(0, limit));
  endfunction

  task automatic randomizeSlots();
    int kind;
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      archDest[s]     = dispatchPkg::archReg_t'($urandom);
      physDest[s]     = dispatchPkg::physReg_t'($urandom);
      oldPhysDest[s]  = dispatchPkg::physReg_t'($urandom);
      physSrc1[s]     = dispatchPkg::physReg_t'($urandom);
      physSrc2[s]     = dispatchPkg::physReg_t'($urandom);
      branchMask[s]   = dispatchPkg::checkpointMask_t'($urandom);
      checkpointId[s] = dispatchPkg::checkpointId_t'($urandom);
      instType[s]     = dispatchPkg::instType_e'($urandom_range(0, 3));
      pc[s]           = $urandom;
      // None, load or store.
      kind       = int'($urandom_range(0, 2));
      isLoad[s]  = (kind == 1);
      isStore[s] = (kind == 2);
    end
  endtask

  // Empty structures, no memory ops, a valid group.
  task automatic setBaseline();
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      isLoad[s]  = 1'b0;
      isStore[s] = 1'b0;
    end
    loadQueueCnt   = '0;
    storeQueueCnt  = '0;
    issueQueueCnt  = '0;
    activeListCnt  = '0;
    renameReady    = 1'b1;
    flagRecoverEX  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = dispatchPkg::checkpointId_t'($urandom);
  endtask

  // Called right after the falling edge; compares just before the rising edge.
  task automatic checkGroup();
    int loads;
    int stores;
    logic expStall;
    logic expReady;
    dispatchPkg::checkpointMask_t expMask;
    #(ClkHalf - 1);
    loads  = 0;
    stores = 0;
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      if (isLoad[s]) loads++;
      if (isStore[s]) stores++;
      expMask = branchMask[s];
      if (ctrlVerified) expMask[ctrlVerifiedId] = 1'b0;
      checkValue($sformatf("updatedBranchMask_o[%0d]", s), 32'(updatedBranchMask[s]),
                 32'(expMask));
      checkValue($sformatf("iqPhysDest_o[%0d]", s), 32'(iqPhysDest[s]), 32'(physDest[s]));
      checkValue($sformatf("iqPhysSrc1_o[%0d]", s), 32'(iqPhysSrc1[s]), 32'(physSrc1[s]));
      checkValue($sformatf("iqPhysSrc2_o[%0d]", s), 32'(iqPhysSrc2[s]), 32'(physSrc2[s]));
      checkValue($sformatf("iqCheckpointId_o[%0d]", s), 32'(iqCheckpointId[s]),
                 32'(checkpointId[s]));
      checkValue($sformatf("iqInstType_o[%0d]", s), 32'(iqInstType[s]), 32'(instType[s]));
      checkValue($sformatf("alArchDest_o[%0d]", s), 32'(alArchDest[s]), 32'(archDest[s]));
      checkValue($sformatf("alPhysDest_o[%0d]", s), 32'(alPhysDest[s]), 32'(physDest[s]));
      checkValue($sformatf("alOldPhysDest_o[%0d]", s), 32'(alOldPhysDest[s]),
                 32'(oldPhysDest[s]));
      checkValue($sformatf("alPc_o[%0d]", s), alPc[s], pc[s]);
      checkValue($sformatf("isLoad_o[%0d]", s), 32'(isLoadOut[s]), 32'(isLoad[s]));
      checkValue($sformatf("isStore_o[%0d]", s), 32'(isStoreOut[s]), 32'(isStore[s]));
    end
    expStall = (loads + int'(loadQueueCnt) > `SIZE_LSQ) ||
               (stores + int'(storeQueueCnt) > `SIZE_LSQ) ||
               (int'(issueQueueCnt) + `DISPATCH_WIDTH > `SIZE_ISSUEQ) ||
               (int'(activeListCnt) + `DISPATCH_WIDTH > `SIZE_ACTIVELIST);
    expReady = !expStall && renameReady && !flagRecoverEX;
    checkValue("stallFrontEnd_o", 32'(stallFrontEnd), 32'(expStall));
    checkValue("backEndReady_o", 32'(backEndReady), 32'(expReady));
    checkCount++;
    assert (!(backEndReady && stallFrontEnd)) else begin
      errorCount++;
      $display("FAIL time=%0t back end reports ready while the front end is stalled", $time);
    end
  endtask

  // Sums of exactly 16 and 17 for each load count, loads then stores.
  task automatic directedLsq();
    for (int q = 0; q < 2; q++) begin
      for (int k = 0; k <= `DISPATCH_WIDTH; k++) begin
        for (int extra = 0; extra < 2; extra++) begin
          @(negedge clk);
          randomizeSlots();
          setBaseline();
          for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            if (q == 0) isLoad[s] = (s < k);
            else isStore[s] = (s < k);
          end
          if (q == 0) loadQueueCnt = dispatchPkg::lsqCnt_t'(`SIZE_LSQ - k + extra);
          else storeQueueCnt = dispatchPkg::lsqCnt_t'(`SIZE_LSQ - k + extra);
          checkGroup();
        end
      end
    end
  endtask

  task automatic directedIqAl();
    int offsets [3] = '{0, 1, `DISPATCH_WIDTH};
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      randomizeSlots();
      setBaseline();
      issueQueueCnt = dispatchPkg::iqCnt_t'(`SIZE_ISSUEQ - `DISPATCH_WIDTH + offsets[i]);
      checkGroup();
      @(negedge clk);
      randomizeSlots();
      setBaseline();
      activeListCnt = dispatchPkg::alCnt_t'(`SIZE_ACTIVELIST - `DISPATCH_WIDTH + offsets[i]);
      checkGroup();
    end
  endtask

  // All combinations of rename ready, recovery and a full active list.
  task automatic directedReady();
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      randomizeSlots();
      setBaseline();
      renameReady   = c[0];
      flagRecoverEX = c[1];
      if (c[2]) activeListCnt = dispatchPkg::alCnt_t'(`SIZE_ACTIVELIST);
      checkGroup();
    end
  endtask

  task automatic directedMask();
    for (int id = 0; id <= `CHECKPOINTS; id++) begin
      @(negedge clk);
      randomizeSlots();
      setBaseline();
      // Last pass leaves the verify flag low.
      ctrlVerified   = (id < `CHECKPOINTS);
      ctrlVerifiedId = dispatchPkg::checkpointId_t'(id);
      for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
        branchMask[s][ctrlVerifiedId] = 1'b1;
      end
      checkGroup();
    end
  endtask

  initial begin
    void'($urandom(32'he7ca));
    randomizeSlots();
    setBaseline();
    wait (!rst);
    directedLsq();
    directedIqAl();
    directedReady();
    directedMask();
    for (int n = 0; n < NumRandom; n++) begin
      @(negedge clk);
      randomizeSlots();
      loadQueueCnt   = dispatchPkg::lsqCnt_t'(biasedCount(`SIZE_LSQ));
      storeQueueCnt  = dispatchPkg::lsqCnt_t'(biasedCount(`SIZE_LSQ));
      issueQueueCnt  = dispatchPkg::iqCnt_t'(biasedCount(`SIZE_ISSUEQ));
      activeListCnt  = dispatchPkg::alCnt_t'(biasedCount(`SIZE_ACTIVELIST));
      renameReady    = 1'($urandom_range(0, 1));
      flagRecoverEX  = ($urandom_range(0, 7) == 0);
      ctrlVerified   = 1'($urandom_range(0, 1));
      ctrlVerifiedId = dispatchPkg::checkpointId_t'($urandom);
      checkGroup();
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    while (cycleCount < CycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the test did not finish within %0d cycles", CycleLimit);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
dispatchPkg.sv
branchMaskUpdate.sv
capacityCheck.sv
dispatch.sv
tbClock.sv
tbDispatch.sv

// ==== Makefile ====
# Verilator build and run for the dispatch stage testbench.

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tbDispatch
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
